// File: src/cb_pkg.sv
package cb_pkg;

    localparam int PORT_NUM        = 8;
    localparam int PORT_W          = 3;
    localparam int NUM_STREAMS     = 4;
    localparam int STREAM_W        = 2;  // table index width
    localparam int HANDLE_W        = 8;
    localparam int SEQ_W           = 16;
    localparam int MAX_HISTORY     = 16;
    localparam int HIST_LEN_W      = 5;  // holds 1..MAX_HISTORY
    localparam int HIST_IDX_W      = 4;  // bit index into history
    localparam int DEFAULT_HISTORY = 8;
    localparam int CNT_W           = 32;
    localparam int REG_ADDR_W      = 8;
    localparam int REG_DATA_W      = 16;

    typedef enum logic [REG_ADDR_W-1:0] {
        REG_HISTORY_LEN = 8'h00,
        REG_STREAM_SEL  = 8'h01,
        REG_CTRL        = 8'h02,  // bit0 stream reset, bit1 counter clear
        REG_RECOV_SEQ   = 8'h03,
        REG_TAKE_ANY    = 8'h04,
        REG_PASSED_LO   = 8'h05,
        REG_PASSED_HI   = 8'h06,
        REG_DISCARD_LO  = 8'h07,
        REG_DISCARD_HI  = 8'h08
    } reg_addr_e;

    typedef enum logic [1:0] {
        VERDICT_PASS          = 2'd0,
        VERDICT_DISCARD_DUP   = 2'd1,  // already seen
        VERDICT_DISCARD_ROGUE = 2'd2   // outside history window
    } verdict_e;

    typedef struct packed {
        logic                valid;
        logic [PORT_W-1:0]   port;
        logic                rtag_flag;
        logic [SEQ_W-1:0]    seq;
        logic [HANDLE_W-1:0] handle;
    } frame_desc_t;

    typedef struct packed {
        logic                valid;
        logic [PORT_W-1:0]   port;
        logic                recover;
        logic [SEQ_W-1:0]    seq;
        logic [STREAM_W-1:0] stream;
    } decoded_t;

    typedef struct packed {
        logic                valid;
        logic [PORT_W-1:0]   port;
        logic                recover;
        logic [STREAM_W-1:0] stream;
        verdict_e            verdict;
    } judged_t;

    typedef struct packed {
        logic [SEQ_W-1:0]       recov_seq;
        logic                   take_any;
        logic [MAX_HISTORY-1:0] history;
    } stream_status_t;

    typedef struct packed {
        logic [STREAM_W-1:0] stream;
        logic                reset;
        logic                clear;
    } stream_ctrl_t;

endpackage

// File: src/cb_frame_decode.sv
`timescale 1ns/1ps

module cb_frame_decode (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  cb_pkg::frame_desc_t i_frame,
    output cb_pkg::decoded_t    o_decoded
);

    logic in_table;  // handle maps to a table entry
    logic recover;

    assign in_table = (i_frame.handle < cb_pkg::HANDLE_W'(cb_pkg::NUM_STREAMS));
    assign recover  = i_frame.rtag_flag && in_table;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_decoded <= '0;
        end else begin
            o_decoded.valid   <= i_frame.valid;
            o_decoded.port    <= i_frame.port;
            o_decoded.recover <= i_frame.valid && recover;
            o_decoded.seq     <= i_frame.seq;
            o_decoded.stream  <= i_frame.handle[cb_pkg::STREAM_W-1:0];  // narrowed index
        end
    end

endmodule

// File: src/cb_vector_recovery.sv
`timescale 1ns/1ps

module cb_vector_recovery (
    input  logic                                   i_clk,
    input  logic                                   i_rst_n,
    input  cb_pkg::decoded_t                       i_decoded,
    input  logic [cb_pkg::HIST_LEN_W-1:0]          i_history_len,
    input  logic                                   i_stream_reset,
    input  logic [cb_pkg::STREAM_W-1:0]            i_reset_stream,
    output cb_pkg::judged_t                        o_judged,
    output cb_pkg::stream_status_t [cb_pkg::NUM_STREAMS-1:0] o_status
);

    cb_pkg::stream_status_t [cb_pkg::NUM_STREAMS-1:0] state_q;
    cb_pkg::stream_status_t        cur;
    cb_pkg::stream_status_t        nxt;
    cb_pkg::verdict_e              verdict;
    logic                          upd;
    logic signed [cb_pkg::SEQ_W-1:0] delta;
    logic signed [cb_pkg::SEQ_W-1:0] hlen;
    logic [cb_pkg::SEQ_W-1:0]      back;    // distance behind recov_seq
    logic                          behind;  // delta <= 0
    logic                          rogue;

    assign cur    = state_q[i_decoded.stream];
    assign delta  = $signed(i_decoded.seq - cur.recov_seq);  // mod 2^16
    assign hlen   = $signed({{(cb_pkg::SEQ_W-cb_pkg::HIST_LEN_W){1'b0}}, i_history_len});
    assign back   = -delta;
    assign behind = delta[cb_pkg::SEQ_W-1] || (delta == '0);
    assign rogue  = (delta >= hlen) || (delta <= -hlen);

    always_comb begin
        nxt     = cur;
        upd     = 1'b0;
        verdict = cb_pkg::VERDICT_PASS;  // bypass frames pass too
        if (i_decoded.valid && i_decoded.recover) begin
            if (cur.take_any) begin
                nxt.recov_seq = i_decoded.seq;
                nxt.take_any  = 1'b0;
                nxt.history   = {{(cb_pkg::MAX_HISTORY-1){1'b0}}, 1'b1};
                upd           = 1'b1;
            end else if (rogue) begin
                verdict = cb_pkg::VERDICT_DISCARD_ROGUE;
            end else if (behind) begin
                if (cur.history[back[cb_pkg::HIST_IDX_W-1:0]]) begin
                    verdict = cb_pkg::VERDICT_DISCARD_DUP;
                end else begin
                    nxt.history[back[cb_pkg::HIST_IDX_W-1:0]] = 1'b1;
                    upd = 1'b1;
                end
            end else begin
                // window slides forward, new seq sits at bit 0
                nxt.recov_seq = i_decoded.seq;
                nxt.history   = (cur.history << delta[cb_pkg::HIST_IDX_W-1:0]) |
                                {{(cb_pkg::MAX_HISTORY-1){1'b0}}, 1'b1};
                upd           = 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int s = 0; s < cb_pkg::NUM_STREAMS; s++) begin
                state_q[s].recov_seq <= '0;
                state_q[s].take_any  <= 1'b1;
                state_q[s].history   <= '0;
            end
        end else begin
            for (int s = 0; s < cb_pkg::NUM_STREAMS; s++) begin
                if (i_stream_reset && (i_reset_stream == cb_pkg::STREAM_W'(s))) begin
                    state_q[s].recov_seq <= '0;  // reset beats frame update
                    state_q[s].take_any  <= 1'b1;
                    state_q[s].history   <= '0;
                end else if (upd && (i_decoded.stream == cb_pkg::STREAM_W'(s))) begin
                    state_q[s] <= nxt;
                end
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_judged <= '0;
        end else begin
            o_judged.valid   <= i_decoded.valid;
            o_judged.port    <= i_decoded.port;
            o_judged.recover <= i_decoded.recover;
            o_judged.stream  <= i_decoded.stream;
            o_judged.verdict <= verdict;
        end
    end

    assign o_status = state_q;

endmodule

// File: src/cb_judge_result.sv
`timescale 1ns/1ps

module cb_judge_result (
    input  logic                                           i_clk,
    input  logic                                           i_rst_n,
    input  cb_pkg::judged_t                                i_judged,
    input  logic                                           i_cnt_clear,
    input  logic [cb_pkg::STREAM_W-1:0]                    i_clear_stream,
    output logic [cb_pkg::PORT_NUM-1:0]                    o_pass_en,
    output logic [cb_pkg::PORT_NUM-1:0]                    o_discard_en,
    output logic [cb_pkg::PORT_NUM-1:0]                    o_judge_finish,
    output logic [cb_pkg::NUM_STREAMS-1:0][cb_pkg::CNT_W-1:0] o_passed_cnt,
    output logic [cb_pkg::NUM_STREAMS-1:0][cb_pkg::CNT_W-1:0] o_discarded_cnt
);

    logic [cb_pkg::PORT_NUM-1:0] port_oh;
    logic                        is_pass;

    assign port_oh = cb_pkg::PORT_NUM'(1) << i_judged.port;
    assign is_pass = (i_judged.verdict == cb_pkg::VERDICT_PASS);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_judge_finish <= '0;
            o_pass_en      <= '0;
            o_discard_en   <= '0;
        end else begin
            o_judge_finish <= i_judged.valid ? port_oh : '0;
            o_pass_en      <= (i_judged.valid && is_pass) ? port_oh : '0;
            o_discard_en   <= (i_judged.valid && !is_pass) ? port_oh : '0;
        end
    end

    // only recoverable frames count, wrap on overflow
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_passed_cnt    <= '0;
            o_discarded_cnt <= '0;
        end else begin
            for (int s = 0; s < cb_pkg::NUM_STREAMS; s++) begin
                if (i_cnt_clear && (i_clear_stream == cb_pkg::STREAM_W'(s))) begin
                    o_passed_cnt[s]    <= '0;
                    o_discarded_cnt[s] <= '0;
                end else if (i_judged.valid && i_judged.recover &&
                             (i_judged.stream == cb_pkg::STREAM_W'(s))) begin
                    if (is_pass) begin
                        o_passed_cnt[s] <= o_passed_cnt[s] + 1'b1;
                    end else begin
                        o_discarded_cnt[s] <= o_discarded_cnt[s] + 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: src/cb_regs.sv
`timescale 1ns/1ps

module cb_regs (
    input  logic                                           i_clk,
    input  logic                                           i_rst_n,
    input  logic                                           i_reg_we,
    input  logic [cb_pkg::REG_ADDR_W-1:0]                  i_reg_wr_addr,
    input  logic [cb_pkg::REG_DATA_W-1:0]                  i_reg_wr_data,
    input  logic                                           i_reg_rd,
    input  logic [cb_pkg::REG_ADDR_W-1:0]                  i_reg_rd_addr,
    output logic [cb_pkg::REG_DATA_W-1:0]                  o_reg_rd_data,
    output logic                                           o_reg_rd_valid,
    input  cb_pkg::stream_status_t [cb_pkg::NUM_STREAMS-1:0] i_status,
    input  logic [cb_pkg::NUM_STREAMS-1:0][cb_pkg::CNT_W-1:0] i_passed_cnt,
    input  logic [cb_pkg::NUM_STREAMS-1:0][cb_pkg::CNT_W-1:0] i_discarded_cnt,
    output logic [cb_pkg::HIST_LEN_W-1:0]                  o_history_len,
    output logic                                           o_stream_reset,
    output logic                                           o_cnt_clear,
    output logic [cb_pkg::STREAM_W-1:0]                    o_sel_stream
);

    logic [cb_pkg::HIST_LEN_W-1:0] history_len_q;
    logic [cb_pkg::STREAM_W-1:0]   sel_q;
    cb_pkg::stream_ctrl_t          ctrl_q;   // one-cycle command
    cb_pkg::stream_status_t        cur;
    logic [cb_pkg::CNT_W-1:0]      passed;
    logic [cb_pkg::CNT_W-1:0]      discarded;
    logic [cb_pkg::REG_DATA_W-1:0] rd_mux;
    logic                          len_ok;

    assign len_ok = (i_reg_wr_data != '0) &&
                    (i_reg_wr_data <= cb_pkg::REG_DATA_W'(cb_pkg::MAX_HISTORY));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            history_len_q <= cb_pkg::HIST_LEN_W'(cb_pkg::DEFAULT_HISTORY);
            sel_q         <= '0;
            ctrl_q        <= '0;
        end else begin
            ctrl_q.reset <= 1'b0;  // self clearing
            ctrl_q.clear <= 1'b0;
            if (i_reg_we) begin
                case (cb_pkg::reg_addr_e'(i_reg_wr_addr))
                    cb_pkg::REG_HISTORY_LEN: begin
                        if (len_ok) begin
                            history_len_q <= i_reg_wr_data[cb_pkg::HIST_LEN_W-1:0];
                        end
                    end
                    cb_pkg::REG_STREAM_SEL: sel_q <= i_reg_wr_data[cb_pkg::STREAM_W-1:0];
                    cb_pkg::REG_CTRL: begin
                        ctrl_q.stream <= sel_q;
                        ctrl_q.reset  <= i_reg_wr_data[0];
                        ctrl_q.clear  <= i_reg_wr_data[1];
                    end
                    default: ;  // status regs are read only
                endcase
            end
        end
    end

    assign cur       = i_status[sel_q];
    assign passed    = i_passed_cnt[sel_q];
    assign discarded = i_discarded_cnt[sel_q];

    always_comb begin
        case (cb_pkg::reg_addr_e'(i_reg_rd_addr))
            cb_pkg::REG_HISTORY_LEN: rd_mux = {{(cb_pkg::REG_DATA_W-cb_pkg::HIST_LEN_W){1'b0}},
                                               history_len_q};
            cb_pkg::REG_STREAM_SEL:  rd_mux = {{(cb_pkg::REG_DATA_W-cb_pkg::STREAM_W){1'b0}},
                                               sel_q};
            cb_pkg::REG_RECOV_SEQ:   rd_mux = cur.recov_seq;
            cb_pkg::REG_TAKE_ANY:    rd_mux = {{(cb_pkg::REG_DATA_W-1){1'b0}}, cur.take_any};
            cb_pkg::REG_PASSED_LO:   rd_mux = passed[cb_pkg::REG_DATA_W-1:0];
            cb_pkg::REG_PASSED_HI:   rd_mux = passed[cb_pkg::CNT_W-1:cb_pkg::REG_DATA_W];
            cb_pkg::REG_DISCARD_LO:  rd_mux = discarded[cb_pkg::REG_DATA_W-1:0];
            cb_pkg::REG_DISCARD_HI:  rd_mux = discarded[cb_pkg::CNT_W-1:cb_pkg::REG_DATA_W];
            default:                 rd_mux = '0;  // ctrl and unknown
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_reg_rd_valid <= 1'b0;
            o_reg_rd_data  <= '0;
        end else begin
            o_reg_rd_valid <= i_reg_rd;
            if (i_reg_rd) begin
                o_reg_rd_data <= rd_mux;
            end
        end
    end

    assign o_history_len  = history_len_q;
    assign o_stream_reset = ctrl_q.reset;
    assign o_cnt_clear    = ctrl_q.clear;
    assign o_sel_stream   = ctrl_q.stream;  // stream the pulse acts on

endmodule

// File: src/tsn_cb_top.sv
`timescale 1ns/1ps

module tsn_cb_top (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  cb_pkg::frame_desc_t           i_frame,
    output logic [cb_pkg::PORT_NUM-1:0]   o_pass_en,
    output logic [cb_pkg::PORT_NUM-1:0]   o_discard_en,
    output logic [cb_pkg::PORT_NUM-1:0]   o_judge_finish,
    input  logic                          i_reg_we,
    input  logic [cb_pkg::REG_ADDR_W-1:0] i_reg_wr_addr,
    input  logic [cb_pkg::REG_DATA_W-1:0] i_reg_wr_data,
    input  logic                          i_reg_rd,
    input  logic [cb_pkg::REG_ADDR_W-1:0] i_reg_rd_addr,
    output logic [cb_pkg::REG_DATA_W-1:0] o_reg_rd_data,
    output logic                          o_reg_rd_valid
);

    cb_pkg::decoded_t                                 decoded;
    cb_pkg::judged_t                                  judged;
    cb_pkg::stream_status_t [cb_pkg::NUM_STREAMS-1:0] status;
    logic [cb_pkg::NUM_STREAMS-1:0][cb_pkg::CNT_W-1:0] passed_cnt;
    logic [cb_pkg::NUM_STREAMS-1:0][cb_pkg::CNT_W-1:0] discarded_cnt;
    logic [cb_pkg::HIST_LEN_W-1:0]                    history_len;
    logic                                             stream_reset;
    logic                                             cnt_clear;
    logic [cb_pkg::STREAM_W-1:0]                      sel_stream;

    cb_frame_decode u_cb_frame_decode (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_frame   (i_frame),
        .o_decoded (decoded)
    );

    cb_vector_recovery u_cb_vector_recovery (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_decoded      (decoded),
        .i_history_len  (history_len),
        .i_stream_reset (stream_reset),
        .i_reset_stream (sel_stream),
        .o_judged       (judged),
        .o_status       (status)
    );

    cb_judge_result u_cb_judge_result (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_judged        (judged),
        .i_cnt_clear     (cnt_clear),
        .i_clear_stream  (sel_stream),
        .o_pass_en       (o_pass_en),
        .o_discard_en    (o_discard_en),
        .o_judge_finish  (o_judge_finish),
        .o_passed_cnt    (passed_cnt),
        .o_discarded_cnt (discarded_cnt)
    );

    cb_regs u_cb_regs (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_reg_we        (i_reg_we),
        .i_reg_wr_addr   (i_reg_wr_addr),
        .i_reg_wr_data   (i_reg_wr_data),
        .i_reg_rd        (i_reg_rd),
        .i_reg_rd_addr   (i_reg_rd_addr),
        .o_reg_rd_data   (o_reg_rd_data),
        .o_reg_rd_valid  (o_reg_rd_valid),
        .i_status        (status),
        .i_passed_cnt    (passed_cnt),
        .i_discarded_cnt (discarded_cnt),
        .o_history_len   (history_len),
        .o_stream_reset  (stream_reset),
        .o_cnt_clear     (cnt_clear),
        .o_sel_stream    (sel_stream)
    );

endmodule

// File: verif/cb_checker.sv
`timescale 1ns/1ps

module cb_checker (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic [cb_pkg::PORT_NUM-1:0]   i_pass_en,
    input  logic [cb_pkg::PORT_NUM-1:0]   i_discard_en,
    input  logic [cb_pkg::PORT_NUM-1:0]   i_judge_finish,
    input  logic [cb_pkg::REG_DATA_W-1:0] i_rd_data,
    input  logic                          i_rd_valid,
    input  logic                          i_exp_frame,
    input  logic [cb_pkg::PORT_W-1:0]     i_exp_port,
    input  logic                          i_exp_pass,
    input  logic                          i_exp_rd,
    input  logic [cb_pkg::REG_DATA_W-1:0] i_exp_rd_data,
    input  logic                          i_test_done,
    input  logic [8*24-1:0]               i_test_name,
    input  logic                          i_all_done,
    output logic                          o_idle,
    output int                            o_errors
);

    typedef struct packed {
        logic                      valid;
        logic [cb_pkg::PORT_W-1:0] port;
        logic                      pass;
    } exp_frame_t;

    exp_frame_t [2:0]              pipe;  // lines up with the 3 cycle frame latency
    logic                          rd_pend;
    logic [cb_pkg::REG_DATA_W-1:0] rd_exp;
    logic [cb_pkg::PORT_NUM-1:0]   exp_oh;
    logic [cb_pkg::PORT_NUM-1:0]   exp_pass_oh;
    logic [cb_pkg::PORT_NUM-1:0]   exp_disc_oh;
    int                            errors       = 0;
    int                            test_errs    = 0;
    int                            tests_run    = 0;
    int                            tests_failed = 0;

    assign o_idle = !(i_exp_frame || i_exp_rd || rd_pend ||
                      pipe[0].valid || pipe[1].valid || pipe[2].valid);
    assign o_errors    = errors;
    assign exp_oh      = pipe[2].valid ? (cb_pkg::PORT_NUM'(1) << pipe[2].port) : '0;
    assign exp_pass_oh = pipe[2].pass ? exp_oh : '0;
    assign exp_disc_oh = pipe[2].pass ? '0 : exp_oh;

    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            pipe    <= '0;
            rd_pend <= 1'b0;
            rd_exp  <= '0;
        end else begin
            // no expected frame means all pulses low
            if (i_judge_finish !== exp_oh || i_pass_en !== exp_pass_oh ||
                i_discard_en !== exp_disc_oh) begin
                $display("[FAIL] t=%0d ns: port %0d expected %0s, got finish=%b pass=%b discard=%b",
                         $time, pipe[2].port,
                         pipe[2].valid ? (pipe[2].pass ? "pass" : "discard") : "no pulse",
                         i_judge_finish, i_pass_en, i_discard_en);
                errors++;
                test_errs++;
            end
            if (rd_pend) begin
                if (!i_rd_valid || i_rd_data !== rd_exp) begin
                    $display("[FAIL] t=%0d ns: read data %h valid %b, expected %h",
                             $time, i_rd_data, i_rd_valid, rd_exp);
                    errors++;
                    test_errs++;
                end
            end else if (i_rd_valid) begin
                $display("read response came without a read request at %0d ns", $time);
                errors++;
                test_errs++;
            end
            if (i_test_done) begin
                tests_run++;
                if (test_errs == 0) begin
                    $display("test %0s: passed", i_test_name);
                end else begin
                    tests_failed++;
                    $display("test %0s: failed with %0d mismatches", i_test_name, test_errs);
                end
                test_errs = 0;
            end
            if (i_all_done) begin
                $display("%0d tests run, %0d passed, %0d failed, %0d mismatches total",
                         tests_run, tests_run - tests_failed, tests_failed, errors);
            end
            pipe    <= {pipe[1:0], i_exp_frame, i_exp_port, i_exp_pass};
            rd_pend <= i_exp_rd;
            rd_exp  <= i_exp_rd_data;
        end
    end

endmodule

// File: verif/tb_tsn_cb_top.sv
`timescale 1ns/1ps

module tb_tsn_cb_top;

    localparam int NAME_W    = 8 * 24;
    localparam int WR_SETTLE = 2;  // ctrl pulse, then stream state

    typedef struct packed {
        logic [7:0]                    kind;
        logic [cb_pkg::PORT_W-1:0]     port;
        logic                          tag;
        logic [cb_pkg::HANDLE_W-1:0]   handle;
        logic [cb_pkg::SEQ_W-1:0]      seq;
        logic                          exp_pass;
        logic [cb_pkg::REG_ADDR_W-1:0] addr;
        logic [cb_pkg::REG_DATA_W-1:0] data;
        logic [NAME_W-1:0]             name;
    } cmd_t;

    logic                          clk = 1'b0;
    logic                          rst_n;
    cb_pkg::frame_desc_t           frame;
    logic                          reg_we;
    logic [cb_pkg::REG_ADDR_W-1:0] reg_wr_addr;
    logic [cb_pkg::REG_DATA_W-1:0] reg_wr_data;
    logic                          reg_rd;
    logic [cb_pkg::REG_ADDR_W-1:0] reg_rd_addr;
    logic [cb_pkg::REG_DATA_W-1:0] reg_rd_data;
    logic                          reg_rd_valid;
    logic [cb_pkg::PORT_NUM-1:0]   pass_en;
    logic [cb_pkg::PORT_NUM-1:0]   discard_en;
    logic [cb_pkg::PORT_NUM-1:0]   judge_finish;
    logic                          exp_frame;
    logic [cb_pkg::PORT_W-1:0]     exp_port;
    logic                          exp_pass;
    logic                          exp_rd;
    logic [cb_pkg::REG_DATA_W-1:0] exp_rd_data;
    logic                          test_done;
    logic                          all_done;
    logic [NAME_W-1:0]             test_name;
    logic                          chk_idle;
    int                            chk_errors;

    cmd_t        cmds[$];
    int unsigned cycle_limit;
    int unsigned cycles;
    logic        load_ok;
    logic        in_test;

    always #5 clk = ~clk;

    tsn_cb_top dut0 (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_frame        (frame),
        .o_pass_en      (pass_en),
        .o_discard_en   (discard_en),
        .o_judge_finish (judge_finish),
        .i_reg_we       (reg_we),
        .i_reg_wr_addr  (reg_wr_addr),
        .i_reg_wr_data  (reg_wr_data),
        .i_reg_rd       (reg_rd),
        .i_reg_rd_addr  (reg_rd_addr),
        .o_reg_rd_data  (reg_rd_data),
        .o_reg_rd_valid (reg_rd_valid)
    );

    cb_checker u_cb_checker (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_pass_en      (pass_en),
        .i_discard_en   (discard_en),
        .i_judge_finish (judge_finish),
        .i_rd_data      (reg_rd_data),
        .i_rd_valid     (reg_rd_valid),
        .i_exp_frame    (exp_frame),
        .i_exp_port     (exp_port),
        .i_exp_pass     (exp_pass),
        .i_exp_rd       (exp_rd),
        .i_exp_rd_data  (exp_rd_data),
        .i_test_done    (test_done),
        .i_test_name    (test_name),
        .i_all_done     (all_done),
        .o_idle         (chk_idle),
        .o_errors       (chk_errors)
    );

    task automatic load_stimulus();
        int              fd;
        int              n;
        int              nlines;
        int              v_port;
        int              v_tag;
        int              v_handle;
        int              v_seq;
        int              v_addr;
        int              v_data;
        logic [7:0]      tok;
        logic [7:0]      verdict;
        logic [NAME_W-1:0] name;
        logic [8*80-1:0] rest;
        cmd_t            c;
        nlines  = 0;
        load_ok = 1'b1;
        fd = $fopen("verif/cb_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open stimulus file verif/cb_stimulus.txt");
            load_ok = 1'b0;
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                nlines++;
                c      = '0;
                c.kind = tok;
                case (tok)
                    "#": n = $fgets(rest, fd);  // column notes
                    "T": begin
                        n      = $fscanf(fd, "%s", name);
                        c.name = name;
                    end
                    "F": begin
                        n = $fscanf(fd, "%d %d %d %h %s", v_port, v_tag, v_handle, v_seq, verdict);
                        if (n != 5) load_ok = 1'b0;
                        c.port     = v_port[cb_pkg::PORT_W-1:0];
                        c.tag      = v_tag[0];
                        c.handle   = v_handle[cb_pkg::HANDLE_W-1:0];
                        c.seq      = v_seq[cb_pkg::SEQ_W-1:0];
                        c.exp_pass = (verdict == "P");
                    end
                    "W", "R": begin
                        n = $fscanf(fd, "%h %h", v_addr, v_data);
                        if (n != 2) load_ok = 1'b0;
                        c.addr = v_addr[cb_pkg::REG_ADDR_W-1:0];
                        c.data = v_data[cb_pkg::REG_DATA_W-1:0];
                    end
                    default: begin
                        $display("unknown command '%s' in stimulus file", tok);
                        load_ok = 1'b0;
                    end
                endcase
                if (tok != "#") cmds.push_back(c);
            end
            $fclose(fd);
        end
        if (!load_ok) $display("stimulus file could not be read completely");
        cycle_limit = 20 * nlines + 100;
    endtask

    task automatic clear_inputs();
        frame     <= '0;
        reg_we    <= 1'b0;
        reg_rd    <= 1'b0;
        exp_frame <= 1'b0;
        exp_rd    <= 1'b0;
        test_done <= 1'b0;
        all_done  <= 1'b0;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        clear_inputs();
    endtask

    // until the checker holds nothing in flight
    task automatic wait_idle();
        idle_cycle();
        @(negedge clk);
        while (!chk_idle) @(negedge clk);
    endtask

    task automatic settle();
        int gap;
        wait_idle();
        gap = $urandom % 3;
        repeat (gap) idle_cycle();
    endtask

    task automatic finish_test();
        wait_idle();
        @(posedge clk);
        clear_inputs();
        test_done <= 1'b1;
        idle_cycle();
    endtask

    task automatic run_cmd(input cmd_t c);
        cb_pkg::frame_desc_t f;
        case (c.kind)
            "T": begin
                if (in_test) finish_test();
                settle();
                test_name <= c.name;
                in_test = 1'b1;
            end
            "F": begin
                f.valid     = 1'b1;
                f.port      = c.port;
                f.rtag_flag = c.tag;
                f.seq       = c.seq;
                f.handle    = c.handle;
                @(posedge clk);  // frames go back to back
                clear_inputs();
                frame     <= f;
                exp_frame <= 1'b1;
                exp_port  <= c.port;
                exp_pass  <= c.exp_pass;
            end
            "W": begin
                settle();
                @(posedge clk);
                clear_inputs();
                reg_we      <= 1'b1;
                reg_wr_addr <= c.addr;
                reg_wr_data <= c.data;
                repeat (WR_SETTLE) idle_cycle();
            end
            default: begin
                settle();
                @(posedge clk);
                clear_inputs();
                reg_rd      <= 1'b1;
                reg_rd_addr <= c.addr;
                exp_rd      <= 1'b1;
                exp_rd_data <= c.data;
            end
        endcase
    endtask

    initial begin
        void'($urandom(32'h1e2941b3));
        rst_n       = 1'b0;
        frame       = '0;
        reg_we      = 1'b0;
        reg_wr_addr = '0;
        reg_wr_data = '0;
        reg_rd      = 1'b0;
        reg_rd_addr = '0;
        exp_frame   = 1'b0;
        exp_port    = '0;
        exp_pass    = 1'b0;
        exp_rd      = 1'b0;
        exp_rd_data = '0;
        test_done   = 1'b0;
        all_done    = 1'b0;
        test_name   = '0;
        in_test     = 1'b0;
        load_stimulus();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        foreach (cmds[i]) run_cmd(cmds[i]);
        if (in_test) finish_test();
        wait_idle();
        @(posedge clk);
        clear_inputs();
        all_done <= 1'b1;
        idle_cycle();
        @(negedge clk);  // checker has printed its counts
        if (load_ok && chk_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #1;
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not end within %0d cycles", cycle_limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: verif/cb_stimulus.txt
# T name | F port tag handle seq P/D | W addr data | R addr expected_data
# port, tag and handle in decimal; seq, addr and data in hex; P pass, D discard
T first_dup
F 0 1 0 0064 P
F 1 1 0 0064 D
F 2 1 0 0064 D
T window_edges
F 0 1 1 0100 P
F 1 1 1 0105 P
F 2 1 1 0103 P
F 3 1 1 0103 D
F 4 1 1 00fd D
F 5 1 1 010d D
F 6 1 1 010c P
F 7 1 1 0105 D
F 0 1 1 0106 P
T bypass
F 4 0 0 0064 P
F 5 1 7 0064 P
F 6 1 4 0064 P
W 01 0000
R 05 0001
R 07 0002
T history_len
W 00 0004
R 00 0004
F 0 1 2 0200 P
F 1 1 2 0204 D
F 2 1 2 0203 P
F 3 1 2 01ff D
F 4 1 2 0201 P
W 00 0000
R 00 0004
W 00 0008
T readback_clear
W 01 0001
R 03 010c
R 04 0000
R 05 0005
R 07 0004
W 02 0002
R 05 0000
R 07 0000
R 20 0000
T stream_reset
W 01 0000
W 02 0001
R 04 0001
F 1 1 0 0064 P
F 2 1 0 0064 D
R 05 0002
R 07 0003

// File: sources.f
src/cb_pkg.sv
src/cb_frame_decode.sv
src/cb_vector_recovery.sv
src/cb_judge_result.sv
src/cb_regs.sv
src/tsn_cb_top.sv
verif/cb_checker.sv
verif/tb_tsn_cb_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, pass only if the log shows it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_tsn_cb_top \
    --Mdir obj_dir -o sim \
    -f sources.f

./obj_dir/sim | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
